//--- rtl/exec_alu.sv
//--------------------------------------------------------------------
// combinational ALU with the six branch condition flags
//--------------------------------------------------------------------

module exec_alu
  import exec_pkg::*;
(
  input  word_t   op0,
  input  word_t   op1,
  input  alu_fn_t fn,
  output word_t   alu_out,
  output logic    branch_cond_eq,
  output logic    branch_cond_ne,
  output logic    branch_cond_lt,
  output logic    branch_cond_ltu,
  output logic    branch_cond_ge,
  output logic    branch_cond_geu
);

  logic [SHAMT_W-1:0] shamt;
  logic               slt_bit;
  logic               sltu_bit;
  logic               diff_signs;

  // only the low bits of op1 shift
  assign shamt = op1[SHAMT_W-1:0];

  assign slt_bit  = $signed(op0) < $signed(op1);
  assign sltu_bit = op0 < op1;

  //--------------------------------------------------------------------
  // function select
  //--------------------------------------------------------------------

  always_comb begin
    case (fn)
      alu_add:    alu_out = op0 + op1;
      alu_sub:    alu_out = op0 - op1;
      alu_sll:    alu_out = op0 << shamt;
      alu_or:     alu_out = op0 | op1;
      alu_slt:    alu_out = {{(XLEN-1){1'b0}}, slt_bit};
      alu_sltu:   alu_out = {{(XLEN-1){1'b0}}, sltu_bit};
      alu_and:    alu_out = op0 & op1;
      alu_xor:    alu_out = op0 ^ op1;
      alu_srl:    alu_out = op0 >> shamt;
      // arithmetic shift keeps the sign
      alu_sra:    alu_out = word_t'($signed(op0) >>> shamt);
      alu_cp_op0: alu_out = op0;
      alu_cp_op1: alu_out = op1;
      // unused codes
      default:    alu_out = '0;
    endcase
  end

  //--------------------------------------------------------------------
  // branch conditions
  //--------------------------------------------------------------------

  // flags assume control picked alu_sub, so alu_out = op0 - op1
  assign diff_signs = op0[XLEN-1] ^ op1[XLEN-1];

  // zero difference means equal
  assign branch_cond_eq = (alu_out == '0);
  assign branch_cond_ne = ~branch_cond_eq;

  // signs differ: the negative operand is the smaller one (signed)
  // signs agree: no overflow, so the difference sign decides
  assign branch_cond_lt = diff_signs ? op0[XLEN-1] : alu_out[XLEN-1];
  assign branch_cond_ge = diff_signs ? op1[XLEN-1] : ~alu_out[XLEN-1];

  // unsigned view flips it, set msb is the larger value
  assign branch_cond_ltu = diff_signs ? op1[XLEN-1] : alu_out[XLEN-1];
  assign branch_cond_geu = diff_signs ? op0[XLEN-1] : ~alu_out[XLEN-1];

endmodule

//--- rtl/exec_multiplier.sv
//--------------------------------------------------------------------
// iterative shift-add 32x32 multiplier, signed and unsigned
// valid/ready request and response, one item in flight
//--------------------------------------------------------------------

module exec_multiplier
  import exec_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  word_t   op_a,
  input  word_t   op_b,
  input  mul_fn_t fn,
  input  logic    req_val,
  output logic    req_rdy,
  output logic    resp_val,
  input  logic    resp_rdy,
  output dword_t  product
);

  mul_state_t           state;
  logic [MUL_CNT_W-1:0] step_cnt;
  logic                 accept;
  logic                 take;
  logic                 last_step;

  // operand sign handling
  logic  a_neg;
  logic  b_neg;
  word_t a_mag;
  word_t b_mag;

  // working registers
  dword_t mcand;
  word_t  mplier;
  dword_t acc;
  logic   negate;

  assign req_rdy  = (state == mul_idle);
  assign resp_val = (state == mul_done);
  assign accept   = req_val & req_rdy;
  assign take     = resp_val & resp_rdy;

  // step count MUL_STEPS is the sign-fix cycle
  assign last_step = (step_cnt == MUL_CNT_W'(MUL_STEPS));

  // magnitudes only for signed requests
  assign a_neg = (fn == mul_signed) && op_a[XLEN-1];
  assign b_neg = (fn == mul_signed) && op_b[XLEN-1];
  assign a_mag = a_neg ? -op_a : op_a;
  assign b_mag = b_neg ? -op_b : op_b;

  assign product = acc;

  //--------------------------------------------------------------------
  // control FSM
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= mul_idle;
      step_cnt <= '0;
    end else begin
      case (state)
        mul_idle: begin
          if (accept) begin
            state    <= mul_busy;
            step_cnt <= '0;
          end
        end
        mul_busy: begin
          if (last_step) begin
            state <= mul_done;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        // hold result until the response is taken
        mul_done: begin
          if (take) begin
            state <= mul_idle;
          end
        end
        default: state <= mul_idle;
      endcase
    end
  end

  //--------------------------------------------------------------------
  // shift-add datapath
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      mcand  <= {{XLEN{1'b0}}, a_mag};
      mplier <= b_mag;
      acc    <= '0;
      negate <= a_neg ^ b_neg;
    end else if (state == mul_busy) begin
      if (last_step) begin
        // restore sign on entry to done
        if (negate) begin
          acc <= -acc;
        end
      end else begin
        if (mplier[0]) begin
          acc <= acc + mcand;
        end
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end
    end
  end

endmodule

//--- rtl/exec_pkg.sv
//--------------------------------------------------------------------
// shared types and constants of the execute stage
// word types, ALU and multiply function codes, multiplier FSM states
//--------------------------------------------------------------------

package exec_pkg;

  //--------------------------------------------------------------------
  // widths and constants
  //--------------------------------------------------------------------

  // data word width
  localparam int XLEN = 32;

  // shift amount taken from low bits of operand 1
  localparam int SHAMT_W = 5;

  // one shift-add per multiplier bit
  localparam int MUL_STEPS = 32;

  // counter covers 0..MUL_STEPS, last value is the sign-fix cycle
  localparam int MUL_CNT_W = $clog2(MUL_STEPS + 1);

  //--------------------------------------------------------------------
  // types
  //--------------------------------------------------------------------

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [2*XLEN-1:0] dword_t;

  // pipeline register reset value
  localparam word_t RESET_WORD = '0;

  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_or     = 4'd3,
    alu_slt    = 4'd4,
    alu_sltu   = 4'd5,
    alu_and    = 4'd6,
    alu_xor    = 4'd7,
    alu_srl    = 4'd8,
    alu_sra    = 4'd9,
    alu_cp_op0 = 4'd10,
    alu_cp_op1 = 4'd11
  } alu_fn_t;

  typedef enum logic [0:0] {
    mul_signed   = 1'b0,
    mul_unsigned = 1'b1
  } mul_fn_t;

  typedef enum logic [1:0] {
    mul_idle = 2'd0,
    mul_busy = 2'd1,
    mul_done = 2'd2
  } mul_state_t;

endpackage

//--- rtl/exec_result_sel.sv
//--------------------------------------------------------------------
// product word select, execute result select, X to M register
//--------------------------------------------------------------------

module exec_result_sel
  import exec_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   stall_m,
  input  word_t  alu_out,
  input  dword_t product,
  input  logic   hi_sel,
  input  logic   exec_sel,
  output word_t  result_m
);

  word_t mul_word;
  word_t exec_word;

  //--------------------------------------------------------------------
  // result muxes
  //--------------------------------------------------------------------

  // high half for mulh-style results, low half otherwise
  always_comb begin
    if (hi_sel) begin
      mul_word = product[2*XLEN-1:XLEN];
    end else begin
      mul_word = product[XLEN-1:0];
    end
  end

  // exec_sel high picks the multiplier
  always_comb begin
    if (exec_sel) begin
      exec_word = mul_word;
    end else begin
      exec_word = alu_out;
    end
  end

  //--------------------------------------------------------------------
  // X to M pipeline register
  //--------------------------------------------------------------------

  // holds under stall_m
  always_ff @(posedge clk) begin
    if (reset) begin
      result_m <= RESET_WORD;
    end else if (!stall_m) begin
      result_m <= exec_word;
    end
  end

endmodule

//--- rtl/exec_stage.sv
//--------------------------------------------------------------------
// execute stage top: D to X operand register, ALU, multiplier
// and result select feeding the X to M register
//--------------------------------------------------------------------

module exec_stage
  import exec_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    stall_x,
  input  logic    stall_m,
  input  word_t   op0_d,
  input  word_t   op1_d,
  input  alu_fn_t alu_fn_x,
  input  mul_fn_t mul_fn_x,
  input  logic    mul_req_val,
  output logic    mul_req_rdy,
  output logic    mul_resp_val,
  input  logic    mul_resp_rdy,
  input  logic    mul_hi_sel_x,
  input  logic    exec_sel_x,
  output word_t   result_m,
  output logic    branch_cond_eq,
  output logic    branch_cond_ne,
  output logic    branch_cond_lt,
  output logic    branch_cond_ltu,
  output logic    branch_cond_ge,
  output logic    branch_cond_geu
);

  // execute-stage operands
  word_t  op0_x;
  word_t  op1_x;

  word_t  alu_out_x;
  dword_t product_x;

  //--------------------------------------------------------------------
  // D to X operand register
  //--------------------------------------------------------------------

  // stall_x freezes the operands
  always_ff @(posedge clk) begin
    if (reset) begin
      op0_x <= RESET_WORD;
      op1_x <= RESET_WORD;
    end else if (!stall_x) begin
      op0_x <= op0_d;
      op1_x <= op1_d;
    end
  end

  //--------------------------------------------------------------------
  // execute units, side by side on the same operands
  //--------------------------------------------------------------------

  exec_alu i_exec_alu (
    .op0             (op0_x),
    .op1             (op1_x),
    .fn              (alu_fn_x),
    .alu_out         (alu_out_x),
    .branch_cond_eq  (branch_cond_eq),
    .branch_cond_ne  (branch_cond_ne),
    .branch_cond_lt  (branch_cond_lt),
    .branch_cond_ltu (branch_cond_ltu),
    .branch_cond_ge  (branch_cond_ge),
    .branch_cond_geu (branch_cond_geu)
  );

  // latches its own operand copy on accept
  exec_multiplier i_exec_multiplier (
    .clk      (clk),
    .reset    (reset),
    .op_a     (op0_x),
    .op_b     (op1_x),
    .fn       (mul_fn_x),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .product  (product_x)
  );

  exec_result_sel i_exec_result_sel (
    .clk      (clk),
    .reset    (reset),
    .stall_m  (stall_m),
    .alu_out  (alu_out_x),
    .product  (product_x),
    .hi_sel   (mul_hi_sel_x),
    .exec_sel (exec_sel_x),
    .result_m (result_m)
  );

endmodule

//--- include/exec_ref_model.svh
//--------------------------------------------------------------------
// reference functions for the ALU, branch flags and multiply
//--------------------------------------------------------------------

`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// expected ALU result for one function
function automatic word_t ref_alu(alu_fn_t fn, word_t a, word_t b);
  int unsigned sh;
  sh = b[SHAMT_W-1:0];
  case (fn)
    alu_add:    return a + b;
    alu_sub:    return a - b;
    alu_sll:    return a << sh;
    alu_or:     return a | b;
    alu_slt:    return word_t'($signed(a) < $signed(b));
    alu_sltu:   return word_t'(a < b);
    alu_and:    return a & b;
    alu_xor:    return a ^ b;
    alu_srl:    return a >> sh;
    alu_sra:    return word_t'($signed(a) >>> sh);
    alu_cp_op0: return a;
    alu_cp_op1: return b;
    default:    return '0;
  endcase
endfunction

// flags from plain comparisons
// bit order {eq, ne, lt, ltu, ge, geu}
function automatic logic [5:0] ref_flags(word_t a, word_t b);
  logic eq;
  logic lt;
  logic ltu;
  eq  = (a == b);
  lt  = ($signed(a) < $signed(b));
  ltu = (a < b);
  return {eq, ~eq, lt, ltu, ~lt, ~ltu};
endfunction

// full 64-bit product, sign or zero extended operands
function automatic dword_t ref_mul(mul_fn_t fn, word_t a, word_t b);
  dword_t ea;
  dword_t eb;
  if (fn == mul_signed) begin
    ea = {{XLEN{a[XLEN-1]}}, a};
    eb = {{XLEN{b[XLEN-1]}}, b};
  end else begin
    ea = {{XLEN{1'b0}}, a};
    eb = {{XLEN{1'b0}}, b};
  end
  // low 64 bits of the extended product are exact
  return ea * eb;
endfunction

// one half of the product, as result_m shows it
function automatic word_t ref_mul_word(mul_fn_t fn, word_t a, word_t b,
                                       logic hi);
  dword_t p;
  p = ref_mul(fn, a, b);
  return hi ? p[2*XLEN-1:XLEN] : p[XLEN-1:0];
endfunction

`endif

//--- verif/exec_stage_tb.sv
//--------------------------------------------------------------------
// testbench for the execute stage: clock, reset, LFSR stimulus,
// compare tasks against the reference model, test sequence, report
//--------------------------------------------------------------------

module exec_stage_tb
  import exec_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // cycles any single wait may take
  localparam int WAIT_LIMIT = 100;

  logic    clk;
  logic    reset;
  logic    stall_x, stall_m;
  word_t   op0_d, op1_d;
  alu_fn_t alu_fn_x;
  mul_fn_t mul_fn_x;
  logic    mul_req_val, mul_req_rdy, mul_resp_val, mul_resp_rdy;
  logic    mul_hi_sel_x, exec_sel_x;
  word_t   result_m;
  logic    branch_cond_eq, branch_cond_ne, branch_cond_lt;
  logic    branch_cond_ltu, branch_cond_ge, branch_cond_geu;

  int          errors;
  int          checks;
  int          mark;
  logic        timed_out;
  logic [31:0] lfsr;

  `include "exec_ref_model.svh"

  exec_stage i_exec_stage (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //--------------------------------------------------------------------
  // random numbers
  //--------------------------------------------------------------------

  // fibonacci LFSR, taps 32 22 2 1, one bit per step
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[30:0], lfsr_step()};
    return r;
  endfunction

  function automatic alu_fn_t rand_fn();
    logic [3:0] code;
    code = 4'(rand_bits(4) % 12);
    return alu_fn_t'(code);
  endfunction

  // biased pair: equal, opposite signs, or unrelated
  task automatic rand_pair(output word_t a, output word_t b);
    logic [1:0] mode;
    word_t      r;
    a    = rand_bits(32);
    r    = rand_bits(32);
    mode = 2'(rand_bits(2));
    case (mode)
      2'd0:    b = a;
      2'd1:    b = {~a[XLEN-1], r[XLEN-2:0]};
      default: b = r;
    endcase
  endtask

  //--------------------------------------------------------------------
  // compare tasks and bounded waits
  //--------------------------------------------------------------------

  task automatic check_word(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // order {eq, ne, lt, ltu, ge, geu}
  task automatic check_flags(logic [5:0] got, logic [5:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error time %0t: branch_cond is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error time %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // caller sits on a falling edge
  task automatic wait_req_rdy();
    int n;
    n = 0;
    while (mul_req_rdy !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (mul_req_rdy !== 1'b1) begin
      $display("timeout: the multiplier never became ready for a request");
      timed_out = 1'b1;
    end
  endtask

  // n counts cycles from the accepting edge
  task automatic wait_resp_val(output int n);
    n = 0;
    while (mul_resp_val !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (mul_resp_val !== 1'b1) begin
      $display("timeout: the multiplier never returned a response");
      timed_out = 1'b1;
    end
  endtask

  //--------------------------------------------------------------------
  // stimulus items
  //--------------------------------------------------------------------

  task automatic drive_ops(word_t a, word_t b, alu_fn_t fn);
    @(posedge clk);
    op0_d    <= a;
    op1_d    <= b;
    alu_fn_x <= fn;
  endtask

  // captured one edge later, in result_m after the second
  task automatic alu_item(word_t a, word_t b, alu_fn_t fn);
    drive_ops(a, b, fn);
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
    check_word("result_m", result_m, ref_alu(fn, a, b));
  endtask

  // flags live in the execute cycle
  task automatic flags_item(word_t a, word_t b);
    drive_ops(a, b, alu_sub);
    @(posedge clk);
    @(negedge clk);
    check_flags({branch_cond_eq, branch_cond_ne, branch_cond_lt,
                 branch_cond_ltu, branch_cond_ge, branch_cond_geu}, ref_flags(a, b));
  endtask

  task automatic mul_item(mul_fn_t fn, word_t a, word_t b, logic hi, int hold);
    int n;
    drive_ops(a, b, alu_add);
    mul_fn_x <= fn;
    @(posedge clk);
    @(negedge clk);
    wait_req_rdy();
    if (timed_out) return;
    @(posedge clk);
    mul_req_val <= 1'b1;
    // request taken on this edge, operands free to move on
    @(posedge clk);
    mul_req_val <= 1'b0;
    op0_d       <= rand_bits(32);
    op1_d       <= rand_bits(32);
    @(negedge clk);
    check_bit("mul_req_rdy", mul_req_rdy, 1'b0);
    wait_resp_val(n);
    if (timed_out) return;
    if (n != MUL_STEPS + 1) begin
      errors++;
      $display("multiply response came %0d cycles after the request, not %0d",
               n, MUL_STEPS + 1);
    end
    // response held back
    repeat (hold) begin
      @(posedge clk);
      @(negedge clk);
      check_bit("mul_resp_val", mul_resp_val, 1'b1);
    end
    @(posedge clk);
    mul_hi_sel_x <= hi;
    exec_sel_x   <= 1'b1;
    mul_resp_rdy <= 1'b1;
    @(posedge clk);
    exec_sel_x   <= 1'b0;
    mul_resp_rdy <= 1'b0;
    @(negedge clk);
    check_word("result_m", result_m, ref_mul_word(fn, a, b, hi));
    check_bit("mul_req_rdy", mul_req_rdy, 1'b1);
  endtask

  task automatic stall_m_item(word_t a, word_t b);
    drive_ops(a, b, alu_add);
    @(posedge clk);
    @(posedge clk);
    stall_m <= 1'b1;
    op0_d   <= a + 1;
    repeat (4) begin
      @(negedge clk);
      check_word("result_m", result_m, ref_alu(alu_add, a, b));
      @(posedge clk);
    end
    stall_m <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_word("result_m", result_m, ref_alu(alu_add, a + 1, b));
  endtask

  task automatic stall_x_item(word_t a, word_t b);
    drive_ops(a, b, alu_xor);
    @(posedge clk);
    stall_x <= 1'b1;
    op0_d   <= ~a;
    repeat (4) begin
      @(posedge clk);
      @(negedge clk);
      check_word("result_m", result_m, ref_alu(alu_xor, a, b));
    end
    @(posedge clk);
    stall_x <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
    check_word("result_m", result_m, ref_alu(alu_xor, ~a, b));
  endtask

  task automatic report_test(string name);
    $display("test %-12s done, %0d errors", name, errors - mark);
    mark = errors;
  endtask

  //--------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------

  initial begin
    word_t      a;
    word_t      b;
    logic [5:0] code;
    lfsr         = 32'd4;
    errors       = 0;
    checks       = 0;
    mark         = 0;
    timed_out    = 1'b0;
    reset        = 1'b1;
    stall_x      = 1'b0;
    stall_m      = 1'b0;
    op0_d        = '0;
    op1_d        = '0;
    alu_fn_x     = alu_add;
    mul_fn_x     = mul_signed;
    mul_req_val  = 1'b0;
    mul_resp_rdy = 1'b0;
    mul_hi_sel_x = 1'b0;
    exec_sel_x   = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_word("result_m", result_m, '0);
    check_bit("mul_req_rdy", mul_req_rdy, 1'b1);
    check_bit("mul_resp_val", mul_resp_val, 1'b0);
    report_test("reset");
    for (int i = 0; i < 200; i++) begin
      rand_pair(a, b);
      alu_item(a, b, rand_fn());
    end
    report_test("alu");
    for (int i = 0; i < 100; i++) begin
      rand_pair(a, b);
      flags_item(a, b);
    end
    report_test("branch_flags");
    for (int i = 0; i < 40 && !timed_out; i++) begin
      rand_pair(a, b);
      code = 6'(rand_bits(2));
      mul_item(mul_fn_t'(code[0]), a, b, code[1], 0);
    end
    report_test("multiply");
    // hold 1..16 cycles, then both stalls
    for (int i = 0; i < 4 && !timed_out; i++) begin
      rand_pair(a, b);
      code = 6'(rand_bits(6));
      mul_item(mul_fn_t'(code[0]), a, b, code[1], 1 + code[5:2]);
    end
    for (int i = 0; i < 4 && !timed_out; i++) begin
      rand_pair(a, b);
      stall_m_item(a, b);
      stall_x_item(b, a);
    end
    report_test("backpressure");
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !timed_out)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
rtl/exec_pkg.sv
rtl/exec_alu.sv
rtl/exec_multiplier.sv
rtl/exec_result_sel.sv
rtl/exec_stage.sv
verif/exec_stage_tb.sv
